//--- common/l2_params.svh
/*
 * Size and address-map macros for the second-level cache.
 * Included by the package and by every RTL file that sizes an array
 * or decodes an address. Every size derives from these values.
 */

`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// bus and storage geometry
`define L2_WORD_BITS      32            // bus and data word width
`define L2_BLOCK_WORDS    4             // words per block
`define L2_ASSOC          4             // ways per set
`define L2_SETS           8             // sets in the cache

// address split, tag | set | word | byte
`define L2_OFFSET_BITS    2             // word select within a block
`define L2_SET_BITS       3             // set index
`define L2_TAG_BITS       25            // remaining upper bits

// everything from here up bypasses the cache
`define L2_NONCACHE_START 32'h8000_0000

`endif

//--- common/l2_pkg.sv
/*
 * Shared types for the second-level cache: sized vectors, the packed
 * processor/memory bus structs, the address split, the per-set LRU
 * list and the controller state encoding.
 * Referenced with l2_pkg:: scoped names, compiled before the RTL.
 */

`default_nettype none

`include "l2_params.svh"

package l2_pkg;

    typedef logic [`L2_WORD_BITS-1:0]     word_t;      // address or data word
    typedef logic [`L2_TAG_BITS-1:0]      tag_t;
    typedef logic [`L2_SET_BITS-1:0]      set_idx_t;
    typedef logic [`L2_OFFSET_BITS-1:0]   word_idx_t;  // word within a block
    typedef logic [$clog2(`L2_ASSOC)-1:0] way_idx_t;
    typedef logic [`L2_WORD_BITS/8-1:0]   byte_en_t;   // one bit per byte lane

    // request side of either bus, held until busy drops
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } bus_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        tag_t       tag;
        set_idx_t   set;
        word_idx_t  word;
        logic [1:0] byte_off;
    } decoded_addr_t;

    // victim is the least recently used way, ord1 the most recent
    typedef struct packed {
        way_idx_t victim;
        way_idx_t next_victim;
        way_idx_t ord0;
        way_idx_t ord1;
    } lru_order_t;

    typedef enum logic [1:0] {
        IDLE,
        WB,
        FETCH
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/l2_cache.sv
/*
 * Second-level cache top: write-back, 4-way set associative.
 * Sits between a processor bus and a memory bus, both using the
 * request/busy handshake of l2_pkg::bus_req_t and bus_rsp_t.
 * Only connects the controller, the frame store and the LRU lists.
 */

`timescale 1ns/10ps
`default_nettype none

module l2_cache (
    input  logic             CLK,
    input  logic             nRST,
    input  l2_pkg::bus_req_t proc_req,
    output l2_pkg::bus_rsp_t proc_rsp,
    output l2_pkg::bus_req_t mem_req,
    input  l2_pkg::bus_rsp_t mem_rsp
);

    l2_pkg::decoded_addr_t proc_addr;  // set field feeds the lru lists

    logic                  hit;
    l2_pkg::way_idx_t      hit_way;
    l2_pkg::word_t         hit_word;
    l2_pkg::way_idx_t      victim_way;
    logic                  victim_dirty;
    l2_pkg::tag_t          victim_tag;
    l2_pkg::word_t         victim_word;

    logic                  fill_en;
    logic                  fill_done;
    logic                  clean_en;
    l2_pkg::word_idx_t     word_num;
    logic                  write_en;
    logic                  touch_en;

    assign proc_addr = proc_req.addr;

    l2_ctrl i_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_req     (proc_req),
        .proc_rsp     (proc_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .hit          (hit),
        .hit_word     (hit_word),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_word  (victim_word),
        .fill_en      (fill_en),
        .fill_done    (fill_done),
        .clean_en     (clean_en),
        .word_num     (word_num),
        .write_en     (write_en),
        .touch_en     (touch_en)
    );

    l2_store i_store (
        .CLK          (CLK),
        .nRST         (nRST),
        .addr         (proc_req.addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_word  (victim_word),
        .word_num     (word_num),
        .fill_en      (fill_en),
        .fill_data    (mem_rsp.rdata),   // fetched word straight off the bus
        .fill_done    (fill_done),
        .clean_en     (clean_en),
        .write_en     (write_en),
        .wdata        (proc_req.wdata),
        .byte_en      (proc_req.byte_en)
    );

    l2_lru i_lru (
        .CLK          (CLK),
        .nRST         (nRST),
        .set_idx      (proc_addr.set),
        .touch_en     (touch_en),
        .touch_way    (hit_way),
        .victim_way   (victim_way)
    );

endmodule

`default_nettype wire

//--- hw/l2_lru.sv
/*
 * True LRU replacement lists, one ordered list of ways per set.
 * The victim output for the addressed set is combinational; a touch
 * moves the touched way to the most-recent end at the next edge.
 */

`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_lru (
    input  logic             CLK,
    input  logic             nRST,
    input  l2_pkg::set_idx_t set_idx,
    input  logic             touch_en,
    input  l2_pkg::way_idx_t touch_way,
    output l2_pkg::way_idx_t victim_way
);

    l2_pkg::lru_order_t order [`L2_SETS];
    l2_pkg::lru_order_t cur_order;
    l2_pkg::lru_order_t next_order;
    l2_pkg::way_idx_t   list    [`L2_ASSOC];   // index 0 is least recent
    l2_pkg::way_idx_t   shifted [`L2_ASSOC];

    ////////////////////////////////////////
    // reorder on touch
    ////////////////////////////////////////

    always_comb begin
        logic found;

        found     = 1'b0;
        cur_order = order[set_idx];
        list[0]   = cur_order.victim;
        list[1]   = cur_order.next_victim;
        list[2]   = cur_order.ord0;
        list[3]   = cur_order.ord1;

        // drop the touched way, close the gap toward the victim end
        for (int i = 0; i < `L2_ASSOC - 1; i++) begin
            if (list[i] == touch_way) begin
                found = 1'b1;
            end
            shifted[i] = found ? list[i+1] : list[i];
        end
        shifted[`L2_ASSOC-1] = touch_way;   // now most recent

        next_order.victim      = shifted[0];
        next_order.next_victim = shifted[1];
        next_order.ord0        = shifted[2];
        next_order.ord1        = shifted[3];
    end

    assign victim_way = cur_order.victim;

    ////////////////////////////////////////
    // list storage
    ////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                order[s] <= '{victim: 2'd0, next_victim: 2'd1, ord0: 2'd2, ord1: 2'd3};
            end
        end else if (touch_en) begin
            order[set_idx] <= next_order;
        end
    end

endmodule

`default_nettype wire

//--- l2_cache.f
+incdir+common
common/l2_pkg.sv
hw/l2_lru.sv
l2_store/l2_store.sv
l2_ctrl/l2_ctrl.sv
hw/l2_cache.sv
testbench/l2_mem_model.sv
testbench/l2_cache_checker.sv
testbench/tb_l2_cache.sv

//--- l2_ctrl/l2_ctrl.sv
/*
 * Cache controller: answers hits, routes non-cacheable accesses
 * straight to memory, and runs the miss sequence of an optional
 * writeback of the LRU victim followed by a block fetch.
 * The word counter and memory address step only on accepted words.
 */

`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_ctrl (
    input  logic              CLK,
    input  logic              nRST,
    input  l2_pkg::bus_req_t  proc_req,
    output l2_pkg::bus_rsp_t  proc_rsp,
    output l2_pkg::bus_req_t  mem_req,
    input  l2_pkg::bus_rsp_t  mem_rsp,
    input  logic              hit,
    input  l2_pkg::word_t     hit_word,
    input  logic              victim_dirty,
    input  l2_pkg::tag_t      victim_tag,
    input  l2_pkg::word_t     victim_word,
    output logic              fill_en,
    output logic              fill_done,
    output logic              clean_en,
    output l2_pkg::word_idx_t word_num,
    output logic              write_en,
    output logic              touch_en
);

    l2_pkg::ctrl_state_t   state, next_state;
    l2_pkg::word_idx_t     word_cnt, next_word_cnt;
    l2_pkg::word_t         mem_addr, next_mem_addr;   // current block word address
    l2_pkg::decoded_addr_t da;
    l2_pkg::decoded_addr_t wb_base;
    l2_pkg::decoded_addr_t fetch_base;
    logic                  req;
    logic                  pass_through;
    logic                  last_word;

    assign da           = proc_req.addr;
    assign req          = proc_req.ren | proc_req.wen;
    assign pass_through = (proc_req.addr >= `L2_NONCACHE_START);
    assign last_word    = (word_cnt == l2_pkg::word_idx_t'(`L2_BLOCK_WORDS - 1));
    assign word_num     = word_cnt;

    // block-aligned start addresses for the two miss phases
    assign wb_base    = '{tag: victim_tag, set: da.set, word: '0, byte_off: 2'b00};
    assign fetch_base = '{tag: da.tag, set: da.set, word: '0, byte_off: 2'b00};

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= l2_pkg::IDLE;
            word_cnt <= '0;
            mem_addr <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
            mem_addr <= next_mem_addr;
        end
    end

    ////////////////////////////////////////
    // next state and bus muxing
    ////////////////////////////////////////

    always_comb begin
        next_state       = state;
        next_word_cnt    = word_cnt;
        next_mem_addr    = mem_addr;
        proc_rsp.busy    = 1'b1;                  // busy unless answered
        proc_rsp.rdata   = hit_word;
        mem_req.ren      = 1'b0;
        mem_req.wen      = 1'b0;
        mem_req.addr     = mem_addr;
        mem_req.wdata    = victim_word;
        mem_req.byte_en  = '1;                    // writebacks are full words
        fill_en          = 1'b0;
        fill_done        = 1'b0;
        clean_en         = 1'b0;
        write_en         = 1'b0;
        touch_en         = 1'b0;

        unique case (state)
            l2_pkg::IDLE: begin
                if (pass_through) begin
                    if (req) begin
                        mem_req  = proc_req;      // byte_en goes through as is
                        proc_rsp = mem_rsp;
                    end
                end else if (req && hit) begin
                    proc_rsp.busy = 1'b0;
                    write_en      = proc_req.wen;
                    touch_en      = 1'b1;
                end else if (req) begin
                    // miss, victim way comes from the lru list
                    next_word_cnt = '0;
                    if (victim_dirty) begin
                        next_mem_addr = wb_base;
                        next_state    = l2_pkg::WB;
                    end else begin
                        next_mem_addr = fetch_base;
                        next_state    = l2_pkg::FETCH;
                    end
                end
            end

            l2_pkg::WB: begin
                mem_req.wen = 1'b1;
                if (!mem_rsp.busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                    next_mem_addr = mem_addr + l2_pkg::word_t'(`L2_WORD_BITS / 8);
                    if (last_word) begin
                        clean_en      = 1'b1;
                        next_mem_addr = fetch_base;
                        next_state    = l2_pkg::FETCH;
                    end
                end
            end

            l2_pkg::FETCH: begin
                mem_req.ren = 1'b1;
                if (!mem_rsp.busy) begin
                    fill_en       = 1'b1;
                    next_word_cnt = word_cnt + 1'b1;
                    next_mem_addr = mem_addr + l2_pkg::word_t'(`L2_WORD_BITS / 8);
                    if (last_word) begin
                        fill_done  = 1'b1;         // request retries as a hit
                        next_state = l2_pkg::IDLE;
                    end
                end
            end

            default: begin
                next_state = l2_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- l2_store/l2_store.sv
/*
 * Frame store of the cache: valid, dirty, tag and data per way.
 * Lookup, hit word and victim readout are combinational on addr;
 * fills, tag install, write merge and dirty updates land at the edge.
 * The controller chooses which update runs in a given cycle.
 */

`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_store (
    input  logic              CLK,
    input  logic              nRST,
    input  l2_pkg::word_t     addr,
    output logic              hit,
    output l2_pkg::way_idx_t  hit_way,
    output l2_pkg::word_t     hit_word,
    input  l2_pkg::way_idx_t  victim_way,
    output logic              victim_dirty,
    output l2_pkg::tag_t      victim_tag,
    output l2_pkg::word_t     victim_word,
    input  l2_pkg::word_idx_t word_num,
    input  logic              fill_en,
    input  l2_pkg::word_t     fill_data,
    input  logic              fill_done,
    input  logic              clean_en,
    input  logic              write_en,
    input  l2_pkg::word_t     wdata,
    input  l2_pkg::byte_en_t  byte_en
);

    l2_pkg::decoded_addr_t da;

    logic          valid [`L2_SETS][`L2_ASSOC];
    logic          dirty [`L2_SETS][`L2_ASSOC];
    l2_pkg::tag_t  tags  [`L2_SETS][`L2_ASSOC];
    l2_pkg::word_t data  [`L2_SETS][`L2_ASSOC][`L2_BLOCK_WORDS];

    assign da = addr;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_ASSOC; w++) begin
            if (valid[da.set][w] && (tags[da.set][w] == da.tag)) begin
                hit     = 1'b1;
                hit_way = l2_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit_word = data[da.set][hit_way][da.word];

    // writeback source, word_num walks the block
    assign victim_dirty = dirty[da.set][victim_way];
    assign victim_tag   = tags[da.set][victim_way];
    assign victim_word  = data[da.set][victim_way][word_num];

    ////////////////////////////////////////
    // frame status
    ////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                for (int w = 0; w < `L2_ASSOC; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else begin
            if (fill_done) begin
                valid[da.set][victim_way] <= 1'b1;   // block fully fetched
            end
            if (clean_en) begin
                dirty[da.set][victim_way] <= 1'b0;   // writeback finished
            end
            if (write_en) begin
                dirty[da.set][hit_way] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // tag and data arrays
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            data[da.set][victim_way][word_num] <= fill_data;
        end
        if (fill_done) begin
            tags[da.set][victim_way] <= da.tag;
        end
        if (write_en) begin
            // merge only the enabled byte lanes
            for (int b = 0; b < `L2_WORD_BITS / 8; b++) begin
                if (byte_en[b]) begin
                    data[da.set][hit_way][da.word][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_l2_cache \
    -f l2_cache.f \
    -o sim_l2_cache

./obj_dir/sim_l2_cache | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- testbench/l2_cache_checker.sv
/*
 * Protocol assertions for the cache controller, bound to l2_ctrl.
 * Failures show up as $error and are counted in assert_fails.
 */

`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_cache_checker (
    input logic                CLK,
    input logic                nRST,
    input l2_pkg::ctrl_state_t state,
    input l2_pkg::bus_req_t    proc_req,
    input l2_pkg::bus_req_t    mem_req,
    input logic                fill_done
);

    int unsigned assert_fails = 0;
    logic        pass_through;

    assign pass_through = (proc_req.addr >= `L2_NONCACHE_START);

    mem_one_op: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            $error("memory read and write requested together");
            assert_fails++;
        end

    mem_req_state: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) |-> (state != l2_pkg::IDLE || pass_through))
        else begin
            $error("memory request in IDLE without pass-through");
            assert_fails++;
        end

    fill_done_state: assert property (@(posedge CLK) disable iff (!nRST)
        fill_done |-> (state == l2_pkg::FETCH))
        else begin
            $error("fill_done outside FETCH");
            assert_fails++;
        end

endmodule

`default_nettype wire

//--- testbench/l2_mem_model.sv
/*
 * Word-addressed memory behind the cache's memory bus.
 * An unwritten word reads as its address XOR 32'h5a5a_0000; written
 * words live in a small table. Each word costs at least one busy
 * cycle, with extra random stalls from a seeded $random.
 */

`timescale 1ns/10ps
`default_nettype none

module l2_mem_model (
    input  logic             CLK,
    input  logic             nRST,
    input  l2_pkg::bus_req_t mem_req,
    output l2_pkg::bus_rsp_t mem_rsp
);

    localparam int SLOTS = 32;            // written words kept

    l2_pkg::word_t slot_addr [SLOTS];
    l2_pkg::word_t slot_data [SLOTS];
    int            used;                  // slots filled so far
    int            hit_slot;              // -1 for a never written word
    logic          ready;
    logic          req;
    integer        seed = 32'hcfb7_1eb3;
    l2_pkg::word_t word_addr;
    l2_pkg::word_t cur_word;
    l2_pkg::word_t merged;

    assign req           = mem_req.ren | mem_req.wen;
    assign word_addr     = {mem_req.addr[31:2], 2'b00};
    assign mem_rsp.busy  = !ready;
    assign mem_rsp.rdata = cur_word;

    always_comb begin
        hit_slot = -1;
        for (int i = 0; i < SLOTS; i++) begin
            if (i < used && slot_addr[i] == word_addr) begin
                hit_slot = i;
            end
        end
        cur_word = (hit_slot >= 0) ? slot_data[hit_slot] : (word_addr ^ 32'h5a5a_0000);
        merged   = cur_word;
        for (int b = 0; b < 4; b++) begin
            if (mem_req.byte_en[b]) begin
                merged[b*8 +: 8] = mem_req.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ready <= 1'b0;
            used  <= 0;
        end else if (req && ready) begin
            ready <= 1'b0;                // one wait cycle before the next word
            if (mem_req.wen) begin
                if (hit_slot >= 0) begin
                    slot_data[hit_slot] <= merged;
                end else begin
                    slot_addr[used] <= word_addr;
                    slot_data[used] <= merged;
                    used            <= used + 1;
                end
            end
        end else if (req) begin
            ready <= (($random(seed) & 3) != 0);   // stall about one cycle in four
        end else begin
            ready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_l2_cache.sv
/*
 * Testbench for the second-level cache.
 * Applies a table of processor reads and writes, one at a time, and
 * checks read data and whether the answer came in the request cycle.
 * Memory sits behind the DUT as l2_mem_model; protocol assertions
 * are bound to the controller.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_l2_cache;

    typedef struct packed {
        logic             wr;
        l2_pkg::word_t    addr;
        l2_pkg::word_t    wdata;
        l2_pkg::byte_en_t byte_en;
        l2_pkg::word_t    exp_rdata;
        logic             exp_fast;     // busy low in the first request cycle
    } step_t;

    localparam int   NUM_STEPS      = 25;
    localparam int   RESET_CYCLES   = 16;
    localparam int   TIMEOUT_CYCLES = NUM_STEPS * 200 + RESET_CYCLES;
    localparam logic RD             = 1'b0;
    localparam logic WR             = 1'b1;

    logic             CLK;
    logic             nRST;
    l2_pkg::bus_req_t proc_req;
    l2_pkg::bus_rsp_t proc_rsp;
    l2_pkg::bus_req_t mem_req;
    l2_pkg::bus_rsp_t mem_rsp;

    step_t steps [NUM_STEPS];
    string names [NUM_STEPS];
    int    step_count  = 0;
    int    error_count = 0;
    int    pass_count  = 0;
    int    fail_count  = 0;
    int    cycle_count = 0;

    l2_cache i_dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .proc_req (proc_req),
        .proc_rsp (proc_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    l2_mem_model i_mem (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    bind l2_ctrl l2_cache_checker i_checker (
        .CLK       (CLK),
        .nRST      (nRST),
        .state     (state),
        .proc_req  (proc_req),
        .mem_req   (mem_req),
        .fill_done (fill_done)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // expected values
    ////////////////////////////////////////

    // content of a memory word that was never written
    function automatic l2_pkg::word_t initial_word(input l2_pkg::word_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic l2_pkg::word_t merge_lanes(input l2_pkg::word_t old_word,
                                                  input l2_pkg::word_t new_word,
                                                  input l2_pkg::byte_en_t lanes);
        l2_pkg::word_t result;

        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic add_step(input string name, input logic wr, input l2_pkg::word_t addr,
                            input l2_pkg::word_t wdata, input l2_pkg::byte_en_t byte_en,
                            input l2_pkg::word_t exp_rdata, input logic exp_fast);
        names[step_count]           = name;
        steps[step_count].wr        = wr;
        steps[step_count].addr      = addr;
        steps[step_count].wdata     = wdata;
        steps[step_count].byte_en   = byte_en;
        steps[step_count].exp_rdata = exp_rdata;
        steps[step_count].exp_fast  = exp_fast;
        step_count++;
    endtask

    task automatic load_table();
        // set 1, first access, block hit, partial write
        add_step("first_read",    RD, 32'h0000_0014, '0, '0, initial_word(32'h14), 1'b0);
        add_step("same_block",    RD, 32'h0000_001c, '0, '0, initial_word(32'h1c), 1'b1);
        add_step("write_hit",     WR, 32'h0000_0018, 32'hdead_beef, 4'b0011, '0, 1'b1);
        add_step("read_merged",   RD, 32'h0000_0018, '0, '0,
                 merge_lanes(initial_word(32'h18), 32'hdead_beef, 4'b0011), 1'b1);
        // set 2, lru order, B becomes the victim
        add_step("lru_fill_a",    RD, 32'h0000_0020, '0, '0, initial_word(32'h020), 1'b0);
        add_step("lru_fill_b",    RD, 32'h0000_00a0, '0, '0, initial_word(32'h0a0), 1'b0);
        add_step("lru_fill_c",    RD, 32'h0000_0120, '0, '0, initial_word(32'h120), 1'b0);
        add_step("lru_fill_d",    RD, 32'h0000_01a0, '0, '0, initial_word(32'h1a0), 1'b0);
        add_step("lru_touch_a",   RD, 32'h0000_0024, '0, '0, initial_word(32'h024), 1'b1);
        add_step("lru_evict_b",   RD, 32'h0000_0220, '0, '0, initial_word(32'h220), 1'b0);
        add_step("lru_keep_a",    RD, 32'h0000_0028, '0, '0, initial_word(32'h028), 1'b1);
        add_step("lru_refetch_b", RD, 32'h0000_00a4, '0, '0, initial_word(32'h0a4), 1'b0);
        // set 3, dirty block pushed out by four new tags
        add_step("dirty_write_c", WR, 32'h0000_0134, 32'hcafe_f00d, 4'b1111, '0, 1'b0);
        add_step("dirty_fill_1",  RD, 32'h0000_0030, '0, '0, initial_word(32'h030), 1'b0);
        add_step("dirty_fill_2",  RD, 32'h0000_00b0, '0, '0, initial_word(32'h0b0), 1'b0);
        add_step("dirty_fill_3",  RD, 32'h0000_01b0, '0, '0, initial_word(32'h1b0), 1'b0);
        add_step("dirty_evict_c", RD, 32'h0000_0230, '0, '0, initial_word(32'h230), 1'b0);
        add_step("dirty_reload",  RD, 32'h0000_0134, '0, '0, 32'hcafe_f00d, 1'b0);
        add_step("dirty_other",   RD, 32'h0000_0138, '0, '0, initial_word(32'h138), 1'b1);
        // non-cacheable region
        add_step("pass_write",    WR, 32'h8000_0010, 32'h1234_5678, 4'b1111, '0, 1'b0);
        add_step("pass_read",     RD, 32'h8000_0010, '0, '0, 32'h1234_5678, 1'b0);
        add_step("pass_reread",   RD, 32'h8000_0010, '0, '0, 32'h1234_5678, 1'b0);
        add_step("pass_untouched", RD, 32'h8000_0014, '0, '0,
                 initial_word(32'h8000_0014), 1'b0);
        // partial write, memory keeps the disabled lanes
        add_step("pass_lane_write", WR, 32'h8000_0014, 32'h1122_3344, 4'b0110, '0, 1'b0);
        add_step("pass_lane_read", RD, 32'h8000_0014, '0, '0,
                 merge_lanes(initial_word(32'h8000_0014), 32'h1122_3344, 4'b0110), 1'b0);
    endtask

    ////////////////////////////////////////
    // checking and stimulus
    ////////////////////////////////////////

    task automatic check_value(input string test, input string what,
                               input l2_pkg::word_t expected, input l2_pkg::word_t actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h, actual %h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic run_step(input int idx);
        step_t            s;
        l2_pkg::bus_req_t req_v;
        l2_pkg::word_t    rdata;
        logic             fast;
        int               errors_before;

        s             = steps[idx];
        errors_before = error_count;
        req_v.ren     = !s.wr;
        req_v.wen     = s.wr;
        req_v.addr    = s.addr;
        req_v.wdata   = s.wdata;
        req_v.byte_en = s.byte_en;

        @(posedge CLK);
        proc_req <= req_v;
        @(negedge CLK);
        fast = !proc_rsp.busy;                 // answered in the request cycle
        while (proc_rsp.busy) begin
            @(negedge CLK);
        end
        rdata = proc_rsp.rdata;
        @(posedge CLK);                        // transfer completes here
        proc_req <= '0;

        if (!s.wr) begin
            check_value(names[idx], "rdata", s.exp_rdata, rdata);
        end
        check_value(names[idx], "fast", {31'b0, s.exp_fast}, {31'b0, fast});

        if (error_count == errors_before) begin
            pass_count++;
            $display("%-16s ok", names[idx]);
        end else begin
            fail_count++;
            $display("%-16s fail", names[idx]);
        end
    endtask

    initial begin
        nRST     = 1'b0;
        proc_req = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        for (int i = 0; i < step_count; i++) begin
            run_step(i);
        end

        if (i_dut.i_ctrl.i_checker.assert_fails != 0) begin
            $display("controller checker saw %0d assertion failures",
                     i_dut.i_ctrl.i_checker.assert_fails);
            error_count++;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 step_count, pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // hang guard, sized from the table length
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout, the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
